/* list.f */
verilog/rv_pkg.sv
verilog/core_ctrl.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/reg_bank.sv
verilog/exec_unit.sv
verilog/retire_unit.sv
verilog/rv_core.sv
test/tb_clock.sv
test/rv_core_chk.sv
test/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for rv_core: random program,
// shadow register model and store compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_top;
    import rv_pkg::*;

    logic        clk;
    logic        reset = 1'b1;
    logic        stall_i = 1'b0;
    logic [31:0] instruction_i = '0;
    logic [31:0] mem_data_i = '0;
    logic [31:0] instruction_address_o, mem_address_o, mem_data_o;
    logic        mem_operation_enable_o, mem_write_o;

    logic [31:0] rom [0:1023];
    logic [31:0] ram [0:1023];
    logic [31:0] shadow [0:31];
    logic [63:0] exp_q [$];    // {address, data}
    logic [63:0] exp_entry;
    logic [31:0] pc_gen, st_addr;
    int          value_errors, protocol_errors, timeout_errors;

    localparam logic [31:0] marker_addr = 32'h7fc;

    tb_clock clk_gen (.clk_o(clk));

    rv_core dut (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .instruction_i(instruction_i), .mem_data_i(mem_data_i),
        .instruction_address_o(instruction_address_o),
        .mem_operation_enable_o(mem_operation_enable_o), .mem_write_o(mem_write_o),
        .mem_address_o(mem_address_o), .mem_data_o(mem_data_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memories and stall driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        instruction_i <= rom[instruction_address_o[11:2]];
        if (mem_operation_enable_o && mem_write_o) begin
            ram[mem_address_o[11:2]] <= mem_data_o;
        end else if (mem_operation_enable_o) begin
            mem_data_i <= ram[mem_address_o[11:2]];    // held until next read
        end
        stall_i <= !reset && ($urandom % 6 == 0);
    end

    // ISA result of an alu operation
    function automatic logic [31:0] ref_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic emit(input logic [31:0] w);
        rom[pc_gen[11:2]] = w;
        pc_gen = pc_gen + 32'd4;
    endtask

    task automatic put_reg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 5'd0) shadow[rd] = v;    // x0 stays zero
    endtask

    task automatic emit_r(input logic [2:0] f3, input logic alt, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [4:0] rd);
        emit({1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg});
        put_reg(rd, ref_op(f3, alt, shadow[rs1], shadow[rs2]));
    endtask

    task automatic emit_i(input logic [2:0] f3, input logic [11:0] imm,
                          input logic [4:0] rs1, input logic [4:0] rd);
        logic alt;
        alt = (f3 == 3'd5) && imm[10];
        emit({imm, rs1, f3, rd, op_imm});
        put_reg(rd, ref_op(f3, alt, shadow[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [19:0] upper;
        upper = v[31:12] + {19'b0, v[11]};
        emit({upper, rd, op_lui});
        put_reg(rd, {upper, 12'b0});
        emit_i(3'd0, v[11:0], rd, rd);
    endtask

    task automatic emit_store(input logic [4:0] rs2, input logic [11:0] imm);
        emit({imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store});
    endtask

    task automatic store_reg(input logic [4:0] rs2);
        emit_store(rs2, st_addr[11:0]);
        exp_q.push_back({st_addr, shadow[rs2]});
        st_addr = st_addr + 32'd4;
    endtask

    function automatic logic [4:0] src_reg();
        return 5'(1 + $urandom % 10);
    endfunction

    function automatic logic [4:0] dst_reg();
        return 5'(11 + $urandom % 10);
    endfunction

    task automatic build_program();
        logic [2:0]  f3;
        logic        alt, taken;
        logic [4:0]  a, b, prev;
        logic [31:0] lw_addr, jpc;
        for (int i = 0; i < 1024; i++) begin
            rom[i] = {20'b0, 5'd0, op_jal};          // jal x0, 0 parks the core
            ram[i] = 32'h5a5a0000 ^ (i * 32'h00010004);
        end
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        pc_gen  = '0;
        st_addr = 32'h100;
        // register-register operations on random operands
        for (int round = 0; round < 3; round++) begin
            for (int r = 1; r <= 10; r++) load_const(5'(r), $urandom);
            for (int k = 0; k < 10; k++) begin
                f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
                alt = (k >= 8);
                a   = dst_reg();
                emit_r(f3, alt, src_reg(), src_reg(), a);
                store_reg(a);
            end
        end
        // immediate forms and shifts, x1 negative
        load_const(5'd1, $urandom | 32'h8000_0000);
        for (int k = 0; k < 24; k++) begin
            f3 = 3'($urandom % 8);
            a  = dst_reg();
            if (f3 == 3'd1 || f3 == 3'd5) begin
                emit_i(f3, {1'b0, f3 == 3'd5 && ($urandom % 2 == 1), 5'b0, 5'($urandom)},
                       src_reg(), a);
            end else begin
                emit_i(f3, 12'($urandom), src_reg(), a);
            end
            store_reg(a);
        end
        for (int k = 0; k < 3; k++) begin
            emit_i(3'd5, {7'b0100000, 5'($urandom)}, 5'd1, 5'd11);    // sra of negative
            store_reg(5'd11);
        end
        // back to back dependent chains
        for (int c = 0; c < 4; c++) begin
            prev = src_reg();
            for (int s = 0; s < 6; s++) begin
                f3  = 3'($urandom % 8);
                alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1);
                a   = dst_reg();
                emit_r(f3, alt, prev, src_reg(), a);
                prev = a;
            end
            store_reg(prev);
        end
        // store, load back, store again
        for (int k = 0; k < 3; k++) begin
            a       = src_reg();
            lw_addr = st_addr;
            store_reg(a);
            emit_i(3'd0, 12'd0, 5'd0, 5'd0);
            emit({lw_addr[11:0], 5'd0, 3'b010, 5'd21, op_load});
            put_reg(5'd21, shadow[a]);
            store_reg(5'd21);
        end
        // branches over a store, taken ones hide the marker
        for (int k = 0; k < 12; k++) begin
            f3    = (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2);
            a     = src_reg();
            b     = (k >= 6) ? a : src_reg();
            taken = branch_ref(f3, shadow[a], shadow[b]);
            emit({1'b0, 6'd0, b, a, f3, 4'b0100, 1'b0, op_branch});    // offset +8
            if (taken) emit_store(src_reg(), marker_addr[11:0]);
            else store_reg(src_reg());
        end
        jpc = pc_gen;
        emit({1'b0, 10'b0000000100, 1'b0, 8'd0, 5'd22, op_jal});    // jal x22, +8
        emit_store(5'd1, marker_addr[11:0]);
        put_reg(5'd22, jpc + 32'd4);
        store_reg(5'd22);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!reset && mem_operation_enable_o && mem_write_o) begin
            if (exp_q.size() == 0) begin
                $display("unexpected bus write at time %0t to address %h", $time,
                         mem_address_o);
                protocol_errors++;
            end else begin
                exp_entry = exp_q.pop_front();
                if (mem_address_o != exp_entry[63:32]) begin
                    $display("CHECK FAILED time %0t mem_address_o got %h expected %h",
                             $time, mem_address_o, exp_entry[63:32]);
                    value_errors++;
                end
                if (mem_data_o != exp_entry[31:0]) begin
                    $display("CHECK FAILED time %0t mem_data_o got %h expected %h",
                             $time, mem_data_o, exp_entry[31:0]);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        int seed_val;
        int cycles;
        seed_val        = $urandom(32'h1ab);
        value_errors    = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        build_program();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d stores never reached the bus", exp_q.size());
            timeout_errors++;
        end else begin
            cycles = 0;
            while (cycles < 60) begin    // late writes would be unexpected
                @(posedge clk);
                cycles++;
            end
        end
        $display("errors: value %0d, protocol %0d, timeout %0d", value_errors,
                 protocol_errors, timeout_errors);
        if (value_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/rv_core_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data bus assertions for the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rv_core_chk (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        stall_i,
    input wire logic        mem_operation_enable_o,
    input wire logic        mem_write_o,
    input wire logic [31:0] mem_address_o
);
    word_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_operation_enable_o |-> mem_address_o[1:0] == 2'b00)
        else $error("bus address not word aligned");

    write_has_enable: assert property (@(posedge clk) disable iff (reset)
        mem_write_o |-> mem_operation_enable_o)
        else $error("write without enable");

    no_enable_in_stall: assert property (@(posedge clk) disable iff (reset)
        stall_i |-> !mem_operation_enable_o)
        else $error("bus enabled during stall");

    // pipeline is empty right after reset
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !mem_operation_enable_o)
        else $error("bus enabled after reset");

endmodule

bind rv_core rv_core_chk chk (
    .clk(clk), .reset(reset), .stall_i(stall_i),
    .mem_operation_enable_o(mem_operation_enable_o), .mem_write_o(mem_write_o),
    .mem_address_o(mem_address_o)
);

`default_nettype wire

/* test/tb_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, period 40
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_clock (
    output logic clk_o
);
    initial clk_o = 1'b0;

    always #20 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i core top, four stage pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rv_core (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    input  rv_pkg::word_t instruction_i,
    input  rv_pkg::word_t mem_data_i,
    output rv_pkg::word_t instruction_address_o,
    output logic          mem_operation_enable_o,
    output logic          mem_write_o,
    output rv_pkg::word_t mem_address_o,
    output rv_pkg::word_t mem_data_o
);
    import rv_pkg::*;

    fetch_stage_t  fetch_s;
    decode_stage_t decode_s;
    retire_stage_t retire_s;

    tag_t      current_tag, retire_tag;
    logic      jump, jump_req, kill, hazard, retire_valid;
    word_t     jump_target, retire_target;
    reg_addr_t rs1, rs2, exec_rd, wb_rd;
    logic      uses_rs1, uses_rs2, exec_writes;
    word_t     rs1_data, rs2_data, wb_data;
    logic      wb_we;
    logic      load, store;
    word_t     load_addr, store_addr, store_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    core_ctrl u_ctrl (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .retire_tag_i(retire_tag), .retire_valid_i(retire_valid),
        .jump_req_i(jump_req), .jump_target_i(retire_target),
        .exec_rd_i(exec_rd), .exec_writes_i(exec_writes),
        .dec_rs1_i(rs1), .dec_rs2_i(rs2),
        .dec_uses_rs1_i(uses_rs1), .dec_uses_rs2_i(uses_rs2),
        .load_i(load), .load_addr_i(load_addr),
        .store_i(store), .store_addr_i(store_addr), .store_data_i(store_data),
        .current_tag_o(current_tag), .jump_o(jump), .jump_target_o(jump_target),
        .kill_o(kill), .hazard_o(hazard),
        .mem_operation_enable_o(mem_operation_enable_o), .mem_write_o(mem_write_o),
        .mem_address_o(mem_address_o), .mem_data_o(mem_data_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .stall_i(stall_i), .hazard_i(hazard),
        .jump_i(jump), .jump_target_i(jump_target), .current_tag_i(current_tag),
        .instruction_address_o(instruction_address_o), .fetch_o(fetch_s)
    );

    decode_unit u_decode (
        .clk(clk), .reset(reset), .stall_i(stall_i), .hazard_i(hazard),
        .instruction_i(instruction_i), .fetch_i(fetch_s),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_o(rs1), .rs2_o(rs2), .uses_rs1_o(uses_rs1), .uses_rs2_o(uses_rs2),
        .decode_o(decode_s)
    );

    reg_bank u_regs (
        .clk(clk), .reset(reset), .rs1_i(rs1), .rs2_i(rs2),
        .rd_i(wb_rd), .we_i(wb_we), .data_i(wb_data),
        .data1_o(rs1_data), .data2_o(rs2_data)
    );

    exec_unit u_exec (
        .clk(clk), .reset(reset), .stall_i(stall_i), .decode_i(decode_s),
        .load_o(load), .load_addr_o(load_addr),
        .exec_rd_o(exec_rd), .exec_writes_o(exec_writes), .retire_o(retire_s)
    );

    retire_unit u_retire (
        .retire_i(retire_s), .kill_i(kill), .mem_data_i(mem_data_i),
        .reg_we_o(wb_we), .reg_rd_o(wb_rd), .reg_data_o(wb_data),
        .store_o(store), .store_addr_o(store_addr), .store_data_o(store_data),
        .jump_req_o(jump_req), .jump_target_o(retire_target),
        .retire_tag_o(retire_tag), .retire_valid_o(retire_valid)
    );

endmodule

`default_nettype wire

/* verilog/retire_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// retire: write-back, store issue, jump request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module retire_unit (
    input  rv_pkg::retire_stage_t retire_i,
    input  logic                  kill_i,
    input  rv_pkg::word_t         mem_data_i,
    output logic                  reg_we_o,
    output rv_pkg::reg_addr_t     reg_rd_o,
    output rv_pkg::word_t         reg_data_o,
    output logic                  store_o,
    output rv_pkg::word_t         store_addr_o,
    output rv_pkg::word_t         store_data_o,
    output logic                  jump_req_o,
    output rv_pkg::word_t         jump_target_o,
    output rv_pkg::tag_t          retire_tag_o,
    output logic                  retire_valid_o
);
    import rv_pkg::*;

    assign reg_we_o   = retire_i.reg_write && !kill_i && retire_i.rd != '0;
    assign reg_rd_o   = retire_i.rd;
    assign reg_data_o = (retire_i.op == iop_lw) ? mem_data_i : retire_i.result;

    assign store_o      = retire_i.store && !kill_i;
    assign store_addr_o = retire_i.result;
    assign store_data_o = retire_i.store_data;

    // kill is applied by the control block
    assign jump_req_o    = retire_i.jump_req;
    assign jump_target_o = retire_i.jump_target;

    assign retire_tag_o   = retire_i.tag;
    assign retire_valid_o = retire_i.valid;

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute: alu, shifter, branch, load issue
// and the execute to retire register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module exec_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  rv_pkg::decode_stage_t decode_i,
    output logic                  load_o,
    output rv_pkg::word_t         load_addr_o,
    output rv_pkg::reg_addr_t     exec_rd_o,
    output logic                  exec_writes_o,
    output rv_pkg::retire_stage_t retire_o
);
    import rv_pkg::*;

    exec_unit_e    unit;
    word_t         a, b, sum, result;
    logic          taken, writes, is_jump;
    retire_stage_t nxt;

    assign unit    = exec_unit_e'(decode_i.op[5:3]);
    assign a       = decode_i.first;
    assign b       = decode_i.second;
    assign sum     = a + b;
    assign is_jump = decode_i.op inside {iop_jal, iop_jalr};
    assign writes  = unit inside {adder_unit, logical_unit, shifter_unit}
                  || decode_i.op inside {iop_lui, iop_jal, iop_jalr, iop_lw};

    always_comb begin
        result = sum;    // memory unit: effective address
        taken  = 1'b0;
        case (unit)
            bypass_unit:  result = b;
            adder_unit: begin
                case (decode_i.op)
                    iop_sub:  result = a - b;
                    iop_slt:  result = {31'b0, $signed(a) < $signed(b)};
                    iop_sltu: result = {31'b0, a < b};
                    default:  result = sum;
                endcase
            end
            logical_unit: begin
                case (decode_i.op)
                    iop_xor: result = a ^ b;
                    iop_or:  result = a | b;
                    default: result = a & b;
                endcase
            end
            shifter_unit: begin
                case (decode_i.op)
                    iop_sll: result = a << b[4:0];
                    iop_srl: result = a >> b[4:0];
                    default: result = $signed(a) >>> b[4:0];
                endcase
            end
            branch_unit: begin
                result = decode_i.pc + 32'd4;    // link value
                case (decode_i.op)
                    iop_beq:  taken = a == b;
                    iop_bne:  taken = a != b;
                    iop_blt:  taken = $signed(a) < $signed(b);
                    iop_bge:  taken = $signed(a) >= $signed(b);
                    iop_bltu: taken = a < b;
                    iop_bgeu: taken = a >= b;
                    default:  taken = is_jump;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        nxt.op          = decode_i.op;
        nxt.result      = result;
        nxt.jump_target = is_jump ? {sum[31:1], 1'b0} : decode_i.pc + decode_i.third;
        nxt.jump_req    = taken;
        nxt.reg_write   = writes;
        nxt.rd          = decode_i.rd;
        nxt.store       = decode_i.op == iop_sw;
        nxt.store_data  = decode_i.third;
        nxt.tag         = decode_i.tag;
        nxt.valid       = decode_i.valid;
    end

    // load read goes out now, data is taken in retire
    assign load_o        = decode_i.valid && decode_i.op == iop_lw;
    assign load_addr_o   = sum;
    assign exec_rd_o     = decode_i.rd;
    assign exec_writes_o = decode_i.valid && writes;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_o.valid <= 1'b0;
        end else if (!stall_i) begin
            retire_o <= nxt;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file, two reads with write-through
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module reg_bank (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  logic              we_i,
    input  rv_pkg::word_t     data_i,
    output rv_pkg::word_t     data1_o,
    output rv_pkg::word_t     data2_o
);
    import rv_pkg::*;

    word_t regs [31:1];    // x0 has no storage

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) return '0;
        if (we_i && rd_i == addr) return data_i;    // same cycle write
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    always_comb begin
        data1_o = read_port(rs1_i);
        data2_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

/* verilog/decode_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode: operation, immediates, operands
// and the decode to execute register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module decode_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  logic                  hazard_i,
    input  rv_pkg::word_t         instruction_i,
    input  rv_pkg::fetch_stage_t  fetch_i,
    input  rv_pkg::word_t         rs1_data_i,
    input  rv_pkg::word_t         rs2_data_i,
    output rv_pkg::reg_addr_t     rs1_o,
    output rv_pkg::reg_addr_t     rs2_o,
    output logic                  uses_rs1_o,
    output logic                  uses_rs2_o,
    output rv_pkg::decode_stage_t decode_o
);
    import rv_pkg::*;

    instr_u        ins;
    iop_e          op;
    word_t         i_imm, s_imm, b_imm, u_imm, j_imm;
    decode_stage_t nxt;

    // shared by register and immediate forms
    function automatic iop_e alu_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? iop_sub : iop_add;
            3'b001:  return iop_sll;
            3'b010:  return iop_slt;
            3'b011:  return iop_sltu;
            3'b100:  return iop_xor;
            3'b101:  return alt ? iop_sra : iop_srl;
            3'b110:  return iop_or;
            default: return iop_and;
        endcase
    endfunction

    assign ins = instruction_i;

    assign i_imm = {{20{ins.i.imm[11]}}, ins.i.imm};
    assign s_imm = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
    assign b_imm = {{20{ins.b.imm12}}, ins.b.imm11, ins.b.imm10_5, ins.b.imm4_1, 1'b0};
    assign u_imm = {instruction_i[31:12], 12'b0};
    assign j_imm = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    always_comb begin
        op = iop_nop;    // unknown encodings retire as no-ops
        case (ins.r.opcode)
            op_lui:    op = iop_lui;
            op_jal:    op = iop_jal;
            op_jalr:   if (ins.i.funct3 == 3'b000) op = iop_jalr;
            op_load:   if (ins.i.funct3 == 3'b010) op = iop_lw;
            op_store:  if (ins.s.funct3 == 3'b010) op = iop_sw;
            op_imm:    op = alu_op(ins.i.funct3, ins.i.funct3 == 3'b101 && ins.r.funct7[5]);
            op_reg:    if (ins.r.funct7 == 7'b0 || ins.r.funct7 == 7'b0100000)
                           op = alu_op(ins.r.funct3, ins.r.funct7[5]);
            op_branch: begin
                case (ins.b.funct3)
                    3'b000:  op = iop_beq;
                    3'b001:  op = iop_bne;
                    3'b100:  op = iop_blt;
                    3'b101:  op = iop_bge;
                    3'b110:  op = iop_bltu;
                    3'b111:  op = iop_bgeu;
                    default: op = iop_nop;
                endcase
            end
            default:   op = iop_nop;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        nxt.op     = op;
        nxt.first  = rs1_data_i;
        nxt.second = i_imm;        // loads, jalr, immediate alu
        nxt.third  = rs2_data_i;   // store data
        case (ins.r.opcode)
            op_lui:    nxt.second = u_imm;
            op_jal: begin
                nxt.first  = fetch_i.pc;
                nxt.second = j_imm;
            end
            op_store:  nxt.second = s_imm;
            op_reg:    nxt.second = rs2_data_i;
            op_branch: begin
                nxt.second = rs2_data_i;
                nxt.third  = b_imm;
            end
            default:   ;
        endcase
        nxt.pc    = fetch_i.pc;
        nxt.rd    = ins.r.rd;
        nxt.tag   = fetch_i.tag;
        nxt.valid = fetch_i.valid && !hazard_i;    // bubble on hazard
    end

    assign rs1_o      = ins.r.rs1;
    assign rs2_o      = ins.r.rs2;
    assign uses_rs1_o = fetch_i.valid && !(op inside {iop_nop, iop_lui, iop_jal});
    assign uses_rs2_o = fetch_i.valid && op != iop_nop
                     && (ins.r.opcode inside {op_reg, op_branch, op_store});

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_o.valid <= 1'b0;
        end else if (!stall_i) begin
            decode_o <= nxt;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch: program counter and fetch slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fetch_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall_i,
    input  logic                 hazard_i,
    input  logic                 jump_i,
    input  rv_pkg::word_t        jump_target_i,
    input  rv_pkg::tag_t         current_tag_i,
    output rv_pkg::word_t        instruction_address_o,
    output rv_pkg::fetch_stage_t fetch_o
);
    import rv_pkg::*;

    word_t pc;
    logic  advance;

    assign advance = !stall_i && (jump_i || !hazard_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            fetch_o <= '0;
        end else if (advance) begin
            pc      <= jump_i ? jump_target_i : pc + 32'd4;
            fetch_o <= '{pc: pc, tag: current_tag_i, valid: 1'b1};
        end
    end

    // on hold the slot in decode is fetched again
    assign instruction_address_o = advance ? pc : fetch_o.pc;

endmodule

`default_nettype wire

/* verilog/core_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core control: tag, kill, jump, hazard and data bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module core_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall_i,
    input  rv_pkg::tag_t      retire_tag_i,
    input  logic              retire_valid_i,
    input  logic              jump_req_i,
    input  rv_pkg::word_t     jump_target_i,
    input  rv_pkg::reg_addr_t exec_rd_i,
    input  logic              exec_writes_i,
    input  rv_pkg::reg_addr_t dec_rs1_i,
    input  rv_pkg::reg_addr_t dec_rs2_i,
    input  logic              dec_uses_rs1_i,
    input  logic              dec_uses_rs2_i,
    input  logic              load_i,
    input  rv_pkg::word_t     load_addr_i,
    input  logic              store_i,
    input  rv_pkg::word_t     store_addr_i,
    input  rv_pkg::word_t     store_data_i,
    output rv_pkg::tag_t      current_tag_o,
    output logic              jump_o,
    output rv_pkg::word_t     jump_target_o,
    output logic              kill_o,
    output logic              hazard_o,
    output logic              mem_operation_enable_o,
    output logic              mem_write_o,
    output rv_pkg::word_t     mem_address_o,
    output rv_pkg::word_t     mem_data_o
);
    import rv_pkg::*;

    tag_t tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag <= '0;
        end else if (jump_o) begin
            tag <= tag + 3'd1;    // older slots now carry a stale tag
        end
    end

    assign current_tag_o = tag;
    assign kill_o        = !retire_valid_i || (retire_tag_i != tag);
    assign jump_o        = jump_req_i && !kill_o && !stall_i;
    assign jump_target_o = jump_target_i;

    // result in execute not yet in the register bank
    assign hazard_o = exec_writes_i && (exec_rd_i != '0)
                   && ((dec_uses_rs1_i && dec_rs1_i == exec_rd_i)
                   ||  (dec_uses_rs2_i && dec_rs2_i == exec_rd_i));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data bus, store wins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mem_operation_enable_o = !stall_i && (store_i || load_i);
    assign mem_write_o            = !stall_i && store_i;
    assign mem_address_o          = {store_i ? store_addr_i[31:2] : load_addr_i[31:2], 2'b00};
    assign mem_data_o             = store_data_i;

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv core package
// widths, opcodes, operation codes and stage records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      tag_t;      // jump generation

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [2:0] {
        bypass_unit, adder_unit, logical_unit, shifter_unit, branch_unit, memory_unit
    } exec_unit_e;

    // upper three bits select the execution unit
    typedef enum logic [5:0] {
        iop_nop  = 6'b000_000, iop_lui  = 6'b000_001,
        iop_add  = 6'b001_000, iop_sub  = 6'b001_001,
        iop_slt  = 6'b001_010, iop_sltu = 6'b001_011,
        iop_xor  = 6'b010_000, iop_or   = 6'b010_001, iop_and  = 6'b010_010,
        iop_sll  = 6'b011_000, iop_srl  = 6'b011_001, iop_sra  = 6'b011_010,
        iop_beq  = 6'b100_000, iop_bne  = 6'b100_001,
        iop_blt  = 6'b100_010, iop_bge  = 6'b100_011,
        iop_bltu = 6'b100_100, iop_bgeu = 6'b100_101,
        iop_jal  = 6'b100_110, iop_jalr = 6'b100_111,
        iop_lw   = 6'b101_000, iop_sw   = 6'b101_001
    } iop_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        word_t pc;
        tag_t  tag;
        logic  valid;
    } fetch_stage_t;

    typedef struct packed {
        iop_e      op;
        word_t     first;
        word_t     second;
        word_t     third;      // store data or branch offset
        word_t     pc;
        reg_addr_t rd;
        tag_t      tag;
        logic      valid;
    } decode_stage_t;

    typedef struct packed {
        iop_e      op;
        word_t     result;     // also the store address
        word_t     jump_target;
        logic      jump_req;
        logic      reg_write;
        reg_addr_t rd;
        logic      store;
        word_t     store_data;
        tag_t      tag;
        logic      valid;
    } retire_stage_t;

endpackage

`default_nettype wire
